// ==== verilog/isaPkg.sv ====
// Instruction encoding for the decoder and the testbench model, imported where fields are cut
package isaPkg;

    typedef logic [4:0] opcodeT;
    typedef logic [1:0] functT;

    // Opcodes in instr[15:11]
    localparam opcodeT OpHalt = 5'b00000;
    localparam opcodeT OpNop  = 5'b00001;
    localparam opcodeT OpJ    = 5'b00100;
    localparam opcodeT OpAddi = 5'b01000;
    localparam opcodeT OpBeqz = 5'b01100;
    localparam opcodeT OpBnez = 5'b01101;
    localparam opcodeT OpSt   = 5'b10000;
    localparam opcodeT OpLd   = 5'b10001;
    localparam opcodeT OpLbi  = 5'b11000;
    localparam opcodeT OpAluR = 5'b11011;

    // Register-register group
    localparam functT FnAdd = 2'b00;
    localparam functT FnSub = 2'b01;
    localparam functT FnXor = 2'b10;
    localparam functT FnAnd = 2'b11;

    localparam int OpMsb     = 15;
    localparam int OpLsb     = 11;
    localparam int RsMsb     = 10;  // Also LBI destination
    localparam int RsLsb     = 8;
    localparam int RtMsb     = 7;   // Destination for ADDI and LD
    localparam int RtLsb     = 5;
    localparam int RdMsb     = 4;   // ALUR destination
    localparam int RdLsb     = 2;
    localparam int FunctMsb  = 1;
    localparam int FunctLsb  = 0;
    localparam int Imm5Msb   = 4;
    localparam int Imm8Msb   = 7;
    localparam int Disp11Msb = 10;

endpackage

// ==== verilog/pipePkg.sv ====
// Pipeline data types and halt tags, imported by every stage, the top level and the testbench
package pipePkg;

    typedef logic [15:0] dataWordT;
    typedef logic [2:0]  regIdxT;
    typedef logic [7:0]  memAddrT;  // Word address for both memories

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluXor,
        AluAnd,
        AluPassB    // Second operand straight through
    } aluOpT;

    typedef enum logic {
        WbAlu,
        WbMem
    } wbSrcT;

    // Halt marker codes riding in storeData
    localparam dataWordT TagHalt    = 16'hfff1;
    localparam dataWordT TagIllegal = 16'hfff2;

endpackage

// ==== verilog/pipeIf.sv ====
// One pipeline register boundary, instantiated per stage pair in the core top level
`timescale 1ns/1ps
interface pipeIf import pipePkg::*; ();

    logic     valid;
    logic     wrEn;       // Register write
    regIdxT   wrAddr;
    aluOpT    aluOp;
    wbSrcT    wbSrc;
    logic     memRd;
    logic     memWr;
    dataWordT opA;
    dataWordT opB;
    dataWordT storeData;  // Store word or halt tag
    dataWordT result;

    modport src (output valid, wrEn, wrAddr, aluOp, wbSrc, memRd, memWr,
                 output opA, opB, storeData, result);

    modport dst (input valid, wrEn, wrAddr, aluOp, wbSrc, memRd, memWr,
                 input opA, opB, storeData, result);

    // Hazard watch from decode
    modport mon (input valid, wrEn, wrAddr);

endinterface

// ==== verilog/fetchStage.sv ====
// Fetch stage holding the PC, the program memory and the IF/ID register
`timescale 1ns/1ps
module fetchStage import pipePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     run,
    input  logic     progWe,
    input  memAddrT  progAddr,
    input  dataWordT progData,
    input  logic     stall,
    input  logic     redirect,
    input  memAddrT  target,
    input  logic     stopFetch,
    output dataWordT instr,
    output memAddrT  pc,
    output logic     fValid
);

    dataWordT imem [256];
    memAddrT  pcReg;

    // Program load port
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg  <= '0;
            fValid <= 1'b0;
        end else if (redirect) begin
            pcReg  <= target;
            fValid <= 1'b0;                 // Kill wrong-path word
        end else if (!stall) begin
            if (stopFetch || !run) begin
                fValid <= 1'b0;             // PC frozen
            end else begin
                pcReg  <= pcReg + 8'd1;
                fValid <= 1'b1;
            end
        end
    end

    // IF/ID payload, held on stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            instr <= imem[pcReg];
            pc    <= pcReg;
        end
    end

endmodule

// ==== verilog/decodeStage.sv ====
// Decode stage with register file, branch resolution, interlock, halt tracking and ID/EX
`timescale 1ns/1ps
module decodeStage import pipePkg::*, isaPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  dataWordT instr,
    input  memAddrT  pc,
    input  logic     fValid,
    output logic     stall,
    output logic     redirect,
    output memAddrT  target,
    output logic     stopFetch,
    pipeIf.src       idEx,
    pipeIf.mon       exMemWatch,
    pipeIf.dst       memWb,
    output logic     wbValid,
    output regIdxT   wbAddr,
    output dataWordT wbData,
    output logic     halted,
    output logic     err
);

    opcodeT   opcode;
    functT    funct;
    regIdxT   rsIdx;
    regIdxT   rtIdx;
    regIdxT   rdIdx;
    dataWordT regFile [8];
    dataWordT rsVal;
    dataWordT rtVal;
    dataWordT immFive;
    dataWordT immEight;
    memAddrT  disp;
    logic     stopOp;
    logic     sendDown;
    logic     takeBranch;
    logic     readsRs;
    logic     readsRt;
    logic     wrEnD;
    regIdxT   destD;
    aluOpT    aluOpD;
    wbSrcT    wbSrcD;
    logic     memRdD;
    logic     memWrD;
    dataWordT opBD;
    dataWordT storeD;
    logic     exWriting;
    logic     memWriting;
    logic     rsBusy;
    logic     rtBusy;
    logic     issue;
    logic     stoppedQ;
    logic     tagInWb;

    assign opcode   = instr[OpMsb:OpLsb];
    assign funct    = instr[FunctMsb:FunctLsb];
    assign rsIdx    = instr[RsMsb:RsLsb];
    assign rtIdx    = instr[RtMsb:RtLsb];
    assign rdIdx    = instr[RdMsb:RdLsb];
    assign immFive  = dataWordT'($signed(instr[Imm5Msb:0]));
    assign immEight = dataWordT'($signed(instr[Imm8Msb:0]));

    // Retire port is the register file write
    assign wbValid = memWb.valid && memWb.wrEn;
    assign wbAddr  = memWb.wrAddr;
    assign wbData  = memWb.result;

    assign rsVal = (wbValid && wbAddr == rsIdx) ? wbData : regFile[rsIdx];  // Write-through
    assign rtVal = (wbValid && wbAddr == rtIdx) ? wbData : regFile[rtIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbValid) begin
            regFile[wbAddr] <= wbData;
        end
    end

    always_comb begin
        stopOp     = 1'b0;
        sendDown   = 1'b0;
        takeBranch = 1'b0;
        readsRs    = 1'b0;
        readsRt    = 1'b0;
        wrEnD      = 1'b0;
        destD      = rtIdx;
        aluOpD     = AluAdd;
        wbSrcD     = WbAlu;
        memRdD     = 1'b0;
        memWrD     = 1'b0;
        opBD       = immFive;
        storeD     = rtVal;
        case (opcode)
            OpHalt: begin
                stopOp   = 1'b1;
                sendDown = 1'b1;
                aluOpD   = AluPassB;
                storeD   = TagHalt;
            end
            OpNop: sendDown = 1'b0;     // Nothing goes down
            OpJ: begin
                takeBranch = 1'b1;
            end
            OpAddi: begin
                readsRs  = 1'b1;
                wrEnD    = 1'b1;
                sendDown = 1'b1;
            end
            OpBeqz: begin
                readsRs    = 1'b1;
                takeBranch = (rsVal == '0);
            end
            OpBnez: begin
                readsRs    = 1'b1;
                takeBranch = (rsVal != '0);
            end
            OpSt: begin
                readsRs  = 1'b1;
                readsRt  = 1'b1;
                memWrD   = 1'b1;
                sendDown = 1'b1;
            end
            OpLd: begin
                readsRs  = 1'b1;
                wrEnD    = 1'b1;
                memRdD   = 1'b1;
                wbSrcD   = WbMem;
                sendDown = 1'b1;
            end
            OpLbi: begin
                wrEnD    = 1'b1;
                destD    = rsIdx;
                aluOpD   = AluPassB;
                opBD     = immEight;
                sendDown = 1'b1;
            end
            OpAluR: begin
                readsRs  = 1'b1;
                readsRt  = 1'b1;
                wrEnD    = 1'b1;
                destD    = rdIdx;
                opBD     = rtVal;
                sendDown = 1'b1;
                case (funct)
                    FnAdd:   aluOpD = AluAdd;
                    FnSub:   aluOpD = AluSub;
                    FnXor:   aluOpD = AluXor;
                    default: aluOpD = AluAnd;
                endcase
            end
            default: begin              // Undefined opcode
                stopOp   = 1'b1;
                sendDown = 1'b1;
                aluOpD   = AluPassB;
                storeD   = TagIllegal;
            end
        endcase
    end

    // Interlock against writers still in EX or MEM
    assign exWriting  = idEx.valid && idEx.wrEn;
    assign memWriting = exMemWatch.valid && exMemWatch.wrEn;
    assign rsBusy = readsRs && ((exWriting && idEx.wrAddr == rsIdx) ||
                                (memWriting && exMemWatch.wrAddr == rsIdx));
    assign rtBusy = readsRt && ((exWriting && idEx.wrAddr == rtIdx) ||
                                (memWriting && exMemWatch.wrAddr == rtIdx));

    assign stall     = fValid && !stoppedQ && (rsBusy || rtBusy);
    assign issue     = fValid && !stoppedQ && !stall;
    assign redirect  = issue && takeBranch;
    assign stopFetch = stoppedQ || (issue && stopOp);

    // Target wraps at 256 words, so only the low byte of either displacement counts
    assign disp   = instr[Imm8Msb:0];
    assign target = pc + 8'd1 + disp;

    // ID/EX control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
            idEx.wrEn  <= 1'b0;
            idEx.memRd <= 1'b0;
            idEx.memWr <= 1'b0;
        end else begin
            idEx.valid <= issue && sendDown;    // Bubble on stall
            idEx.wrEn  <= wrEnD;
            idEx.memRd <= memRdD;
            idEx.memWr <= memWrD;
        end
    end

    always_ff @(posedge clk) begin
        idEx.wrAddr    <= destD;
        idEx.aluOp     <= aluOpD;
        idEx.wbSrc     <= wbSrcD;
        idEx.opA       <= rsVal;
        idEx.opB       <= opBD;
        idEx.storeData <= storeD;
    end

    assign idEx.result = '0;    // Produced in execute

    // Halt marker seen leaving writeback
    assign tagInWb = memWb.valid && !memWb.wrEn && memWb.aluOp == AluPassB;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stoppedQ <= 1'b0;
            halted   <= 1'b0;
            err      <= 1'b0;
        end else begin
            if (issue && stopOp) begin
                stoppedQ <= 1'b1;
            end
            if (tagInWb && (memWb.storeData == TagHalt || memWb.storeData == TagIllegal)) begin
                halted <= 1'b1;
            end
            if (tagInWb && memWb.storeData == TagIllegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/executeStage.sv ====
// Execute stage with the ALU and the EX/MEM register
`timescale 1ns/1ps
module executeStage import pipePkg::*; (
    input logic clk,
    input logic rstN,
    pipeIf.dst  idEx,
    pipeIf.src  exMem
);

    dataWordT aluOut;

    // Loads and stores come in as AluAdd for the address
    always_comb begin
        case (idEx.aluOp)
            AluAdd:  aluOut = idEx.opA + idEx.opB;
            AluSub:  aluOut = idEx.opA - idEx.opB;
            AluXor:  aluOut = idEx.opA ^ idEx.opB;
            AluAnd:  aluOut = idEx.opA & idEx.opB;
            default: aluOut = idEx.opB;             // PASSB for LBI and halt tag
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
            exMem.wrEn  <= 1'b0;
            exMem.memRd <= 1'b0;
            exMem.memWr <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.wrEn  <= idEx.wrEn;
            exMem.memRd <= idEx.memRd;
            exMem.memWr <= idEx.memWr;
        end
    end

    always_ff @(posedge clk) begin
        exMem.wrAddr    <= idEx.wrAddr;
        exMem.aluOp     <= idEx.aluOp;
        exMem.wbSrc     <= idEx.wbSrc;
        exMem.opA       <= idEx.opA;
        exMem.opB       <= idEx.opB;
        exMem.storeData <= idEx.storeData;
        exMem.result    <= aluOut;
    end

endmodule

// ==== verilog/memoryStage.sv ====
// Memory stage with the data memory, writeback select and the MEM/WB register
`timescale 1ns/1ps
module memoryStage import pipePkg::*; (
    input logic clk,
    input logic rstN,
    pipeIf.dst  exMem,
    pipeIf.src  memWb
);

    dataWordT dmem [256];
    memAddrT  addr;
    dataWordT rdWord;

    assign addr   = memAddrT'(exMem.result);           // Low 8 bits of ALU sum
    assign rdWord = exMem.memRd ? dmem[addr] : '0;

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.memWr) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb.valid <= 1'b0;
            memWb.wrEn  <= 1'b0;
            memWb.memRd <= 1'b0;
            memWb.memWr <= 1'b0;
        end else begin
            memWb.valid <= exMem.valid;
            memWb.wrEn  <= exMem.wrEn;
            memWb.memRd <= exMem.memRd;
            memWb.memWr <= exMem.memWr;
        end
    end

    always_ff @(posedge clk) begin
        memWb.wrAddr    <= exMem.wrAddr;
        memWb.aluOp     <= exMem.aluOp;     // Needed for halt tag
        memWb.wbSrc     <= exMem.wbSrc;
        memWb.opA       <= exMem.opA;
        memWb.opB       <= exMem.opB;
        memWb.storeData <= exMem.storeData;
        memWb.result    <= (exMem.wbSrc == WbMem) ? rdWord : exMem.result;
    end

endmodule

// ==== verilog/cpuCore.sv ====
// Core top level joining the four pipeline stages, driven directly by the testbench
`timescale 1ns/1ps
module cpuCore import pipePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     run,
    input  logic     progWe,
    input  memAddrT  progAddr,
    input  dataWordT progData,
    output logic     wbValid,
    output regIdxT   wbAddr,
    output dataWordT wbData,
    output logic     halted,
    output logic     err
);

    dataWordT instr;
    memAddrT  pc;
    logic     fValid;
    logic     stall;
    logic     redirect;
    memAddrT  target;
    logic     stopFetch;

    pipeIf idEx ();
    pipeIf exMem ();
    pipeIf memWb ();

    fetchStage fetch (
        .clk       (clk),
        .rstN      (rstN),
        .run       (run),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .stopFetch (stopFetch),
        .instr     (instr),
        .pc        (pc),
        .fValid    (fValid)
    );

    decodeStage decode (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .pc         (pc),
        .fValid     (fValid),
        .stall      (stall),
        .redirect   (redirect),
        .target     (target),
        .stopFetch  (stopFetch),
        .idEx       (idEx),
        .exMemWatch (exMem),
        .memWb      (memWb),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .halted     (halted),
        .err        (err)
    );

    executeStage execute (
        .clk   (clk),
        .rstN  (rstN),
        .idEx  (idEx),
        .exMem (exMem)
    );

    memoryStage memory (
        .clk   (clk),
        .rstN  (rstN),
        .exMem (exMem),
        .memWb (memWb)
    );

endmodule

// ==== dv/cpuCore_sva.sv ====
// Concurrent checks on the core's retire and halt outputs, bound to every cpuCore instance
`timescale 1ns/1ps
module cpuCoreSva (
    input logic clk,
    input logic rstN,
    input logic wbValid,
    input logic halted,
    input logic err
);

    property haltHolds;
        @(posedge clk) disable iff (!rstN) halted |=> halted;   // Sticky until reset
    endproperty

    property noRetireWhenHalted;
        @(posedge clk) disable iff (!rstN) halted |-> !wbValid;
    endproperty

    property errMeansHalted;
        @(posedge clk) disable iff (!rstN) err |-> halted;
    endproperty

    assert property (haltHolds) else $error("halted dropped without a reset");
    assert property (noRetireWhenHalted) else $error("wbValid pulsed while halted");
    assert property (errMeansHalted) else $error("err is high while halted is low");

endmodule

bind cpuCore cpuCoreSva sva (
    .clk     (clk),
    .rstN    (rstN),
    .wbValid (wbValid),
    .halted  (halted),
    .err     (err)
);

// ==== dv/cpuCoreTb.sv ====
// Directed and random program tests for the core, checked against a behavioral ISA model
`timescale 1ns/1ps
module cpuCoreTb import pipePkg::*, isaPkg::*; ();

    localparam int ResetCycles = 16;
    localparam int MaxCycles   = 6000;  // Five tests of up to 64 instr at 4 cycles, plus reset and drain
    localparam int ModelSteps  = 1000;

    logic     clk;
    logic     rstN;
    logic     run;
    logic     progWe;
    memAddrT  progAddr;
    dataWordT progData;
    logic     wbValid;
    regIdxT   wbAddr;
    dataWordT wbData;
    logic     halted;
    logic     err;

    dataWordT prog [256];
    int       progLen;
    dataWordT modelRegs [8];
    dataWordT modelMem [256];
    regIdxT   expAddr [$];
    dataWordT expData [$];
    regIdxT   gotAddr [$];
    dataWordT gotData [$];
    string    curTest;
    int       errorCount;
    int       cycleCount;

    cpuCore uut (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .halted   (halted),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < MaxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    function automatic dataWordT iType(opcodeT op, regIdxT rs, regIdxT rt, int imm);
        iType = {op, rs, rt, imm[4:0]};
    endfunction

    function automatic dataWordT rType(functT fn, regIdxT rs, regIdxT rt, regIdxT rd);
        rType = {OpAluR, rs, rt, rd, fn};
    endfunction

    function automatic dataWordT lbiInstr(regIdxT rd, int imm);
        lbiInstr = {OpLbi, rd, imm[7:0]};
    endfunction

    function automatic dataWordT branchInstr(opcodeT op, regIdxT rs, int disp);
        branchInstr = {op, rs, disp[7:0]};
    endfunction

    function automatic dataWordT jumpInstr(int disp);
        jumpInstr = {OpJ, disp[10:0]};
    endfunction

    task automatic emit(input dataWordT word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic expectEqual(input string what, input int got, input int exp);
        assert (got == exp) else begin
            errorCount++;
            $display("** Error at %0t: %s: %s expected %0h, got %0h",
                     $time, curTest, what, exp, got);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping after the first failed check");
        end
    endtask

    task automatic retireModel(input regIdxT r, input dataWordT v);
        modelRegs[r] = v;
        expAddr.push_back(r);
        expData.push_back(v);
    endtask

    // Executes prog with the ISA rules and builds the expected retire list
    task automatic runModel(output logic expErr);
        memAddrT  pcM;
        memAddrT  nextPc;
        dataWordT ir;
        dataWordT imm5;
        dataWordT imm8;
        dataWordT a;
        dataWordT b;
        dataWordT sum;
        int       steps;
        int       i;
        logic     done;
        expAddr.delete();
        expData.delete();
        for (i = 0; i < 8; i++) begin
            modelRegs[i] = '0;
        end
        for (i = 0; i < 256; i++) begin
            modelMem[i] = '0;
        end
        pcM    = '0;
        done   = 1'b0;
        expErr = 1'b0;
        steps  = 0;
        while (!done) begin
            ir     = prog[pcM];
            a      = modelRegs[ir[10:8]];
            b      = modelRegs[ir[7:5]];
            imm5   = {{11{ir[4]}}, ir[4:0]};
            imm8   = {{8{ir[7]}}, ir[7:0]};
            sum    = a + imm5;
            nextPc = pcM + 8'd1;
            case (ir[15:11])
                OpHalt: done = 1'b1;
                OpNop:  nextPc = pcM + 8'd1;
                OpJ:    nextPc = pcM + 8'd1 + ir[7:0];    // Low byte of disp11, mod 256
                OpAddi: retireModel(ir[7:5], sum);
                OpBeqz: if (a == '0) nextPc = pcM + 8'd1 + ir[7:0];
                OpBnez: if (a != '0) nextPc = pcM + 8'd1 + ir[7:0];
                OpSt:   modelMem[sum[7:0]] = b;
                OpLd:   retireModel(ir[7:5], modelMem[sum[7:0]]);
                OpLbi:  retireModel(ir[10:8], imm8);
                OpAluR: begin
                    case (ir[1:0])
                        FnAdd:   retireModel(ir[4:2], a + b);
                        FnSub:   retireModel(ir[4:2], a - b);
                        FnXor:   retireModel(ir[4:2], a ^ b);
                        default: retireModel(ir[4:2], a & b);
                    endcase
                end
                default: begin
                    done   = 1'b1;
                    expErr = 1'b1;
                end
            endcase
            pcM = nextPc;
            steps++;
            if (steps > ModelSteps) begin
                $display("The reference model of test %s never reached a halt", curTest);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Runaway program in the model");
            end
        end
    endtask

    // Reset for 16 cycles, loading words on the way, then finish the load with run low
    task automatic resetAndLoad();
        int i;
        run = 1'b0;
        for (i = 0; i < ResetCycles || i < progLen; i++) begin
            @(negedge clk);
            rstN     = (i >= ResetCycles);
            progWe   = (i < progLen);
            progAddr = memAddrT'(i);
            progData = prog[i[7:0]];
        end
        @(negedge clk);
        rstN   = 1'b1;
        progWe = 1'b0;
    endtask

    task automatic checkIdle();
        @(negedge clk);
        expectEqual("wbValid before run", int'(wbValid), 0);
        expectEqual("halted before run", int'(halted), 0);
        expectEqual("err before run", int'(err), 0);
    endtask

    task automatic runProgram();
        logic expErr;
        int   tail;
        int   i;
        runModel(expErr);
        resetAndLoad();
        checkIdle();
        gotAddr.delete();
        gotData.delete();
        run  = 1'b1;
        tail = 0;
        while (tail < 8) begin      // Keep watching after halt
            @(negedge clk);
            if (wbValid) begin
                gotAddr.push_back(wbAddr);
                gotData.push_back(wbData);
            end
            if (halted || tail > 0) begin
                expectEqual("halted held", int'(halted), 1);
                expectEqual("err", int'(err), int'(expErr));
                tail++;
            end
        end
        for (i = 0; i < gotAddr.size() && i < expAddr.size(); i++) begin
            expectEqual($sformatf("retire %0d register", i), int'(gotAddr[i]), int'(expAddr[i]));
            expectEqual($sformatf("retire %0d value", i), int'(gotData[i]), int'(expData[i]));
        end
        expectEqual("retire count", gotAddr.size(), expAddr.size());
        run = 1'b0;
    endtask

    task automatic chainTest();
        curTest = "chain";
        progLen = 0;
        emit(lbiInstr(3'd1, 5));
        emit(lbiInstr(3'd2, -3));
        emit(iType(OpAddi, 3'd1, 3'd3, 7));
        emit(rType(FnAdd, 3'd3, 3'd2, 3'd4));
        emit(rType(FnSub, 3'd4, 3'd1, 3'd5));
        emit(rType(FnXor, 3'd5, 3'd3, 3'd6));
        emit(rType(FnAnd, 3'd6, 3'd4, 3'd7));
        emit(iType(OpAddi, 3'd7, 3'd1, -16));
        emit(rType(FnAdd, 3'd1, 3'd1, 3'd2));
        emit({OpHalt, 11'd0});
        runProgram();
    endtask

    task automatic memoryTest();
        curTest = "memory";
        progLen = 0;
        emit(lbiInstr(3'd1, 8'h10));            // Base address
        emit(lbiInstr(3'd2, 8'h5a));
        emit(lbiInstr(3'd3, -100));
        emit(iType(OpSt, 3'd1, 3'd2, 0));
        emit(iType(OpSt, 3'd1, 3'd3, 3));
        emit(iType(OpLd, 3'd1, 3'd4, 0));
        emit(iType(OpLd, 3'd1, 3'd5, 3));
        emit(iType(OpAddi, 3'd1, 3'd6, 2));
        emit(iType(OpSt, 3'd6, 3'd5, -1));
        emit(iType(OpLd, 3'd1, 3'd7, 1));
        emit(iType(OpSt, 3'd1, 3'd4, -16));     // Wraps to word 0
        emit(iType(OpLd, 3'd6, 3'd2, -18));
        emit({OpHalt, 11'd0});
        runProgram();
    endtask

    task automatic branchTest();
        curTest = "branch";
        progLen = 0;
        emit(lbiInstr(3'd1, 0));
        emit(lbiInstr(3'd2, 9));
        emit(branchInstr(OpBeqz, 3'd1, 2));     // Taken to 5
        emit(lbiInstr(3'd3, 1));
        emit(lbiInstr(3'd3, 2));
        emit(branchInstr(OpBnez, 3'd1, 3));     // Not taken
        emit(lbiInstr(3'd4, 4));
        emit(branchInstr(OpBnez, 3'd2, 1));     // Taken to 9
        emit(lbiInstr(3'd5, 5));
        emit(branchInstr(OpBeqz, 3'd2, 4));
        emit(jumpInstr(2));                     // To 13
        emit(lbiInstr(3'd6, 6));
        emit({OpHalt, 11'd0});
        emit(lbiInstr(3'd7, 3));
        emit(iType(OpAddi, 3'd7, 3'd7, -1));    // Loop body
        emit(branchInstr(OpBnez, 3'd7, -2));
        emit(jumpInstr(1));
        emit(lbiInstr(3'd6, 6));
        emit({OpHalt, 11'd0});
        runProgram();
    endtask

    task automatic randomTest();
        int k;
        int kind;
        curTest = "random";
        progLen = 0;
        for (k = 0; k < 48; k++) begin
            kind = $urandom_range(2, 0);
            if (kind == 0) begin
                emit(lbiInstr(regIdxT'($urandom_range(7, 0)), $urandom_range(255, 0)));
            end else if (kind == 1) begin
                emit(iType(OpAddi, regIdxT'($urandom_range(7, 0)),
                           regIdxT'($urandom_range(7, 0)), $urandom_range(31, 0)));
            end else begin
                emit(rType(functT'($urandom_range(3, 0)), regIdxT'($urandom_range(7, 0)),
                           regIdxT'($urandom_range(7, 0)), regIdxT'($urandom_range(7, 0))));
            end
        end
        emit({OpHalt, 11'd0});
        runProgram();
    endtask

    task automatic illegalTest();
        curTest = "illegal";
        progLen = 0;
        emit(lbiInstr(3'd1, 20));
        emit(lbiInstr(3'd2, 22));
        emit(rType(FnAdd, 3'd1, 3'd2, 3'd3));
        emit(rType(FnSub, 3'd3, 3'd1, 3'd4));
        emit(16'hf800);                         // Opcode 11111 is undefined
        emit(lbiInstr(3'd5, 1));
        emit(rType(FnAdd, 3'd3, 3'd3, 3'd6));
        emit({OpHalt, 11'd0});
        runProgram();
    endtask

    initial begin
        rstN       = 1'b0;
        run        = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        errorCount = 0;
        void'($urandom(34));
        chainTest();
        memoryTest();
        branchTest();
        randomTest();
        illegalTest();
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== cpuCore.f ====
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeIf.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuCore.sv
dv/cpuCore_sva.sv
dv/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb \
    -f cpuCore.f -Mdir build -o simCpuCore

./build/simCpuCore 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass, see sim.log"
exit 1
